//--- dv/router_tb.sv
module router_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [3:0] NODE_X = 4'd2;
  localparam logic [3:0] NODE_Y = 4'd2;
  localparam int FIFO_DEPTH  = 4;
  localparam int NP          = noc_pkg::NUM_PORTS;
  localparam int TOTAL_FLITS = 5 + 21 + 18 + 8; // sum over tests 2 to 5
  localparam int CYCLE_LIMIT = 20 * TOTAL_FLITS + 200;

  logic                    clk;
  logic                    rst_n;
  noc_pkg::link_t [NP-1:0] in_link;
  noc_pkg::link_t [NP-1:0] out_link;
  logic [NP-1:0]           credit_in;
  logic [NP-1:0]           credit_out;

  noc_pkg::flit_t inject_q [NP][$];    // flits waiting to enter each input
  noc_pkg::flit_t exp_q [NP*NP][$];    // expected flits, output*NP + input
  int             up_credit [NP];      // upstream neighbor view of our FIFO
  int             pending [NP];        // credits owed by downstream neighbor
  int             cur_src [NP];        // input owning the packet in flight
  int             left [NP];
  int             rx_cnt [NP];
  int             inj_cnt [NP];
  int             crd_cnt [NP];
  logic [NP-1:0]  hold;
  logic           rand_delay;
  int             serial;
  int             errors;
  int             tests_passed;
  int             tests_failed;
  int             cycles;

  router_node #(.NODE_X(NODE_X), .NODE_Y(NODE_Y), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_link    (in_link),
    .credit_out (credit_out),
    .out_link   (out_link),
    .credit_in  (credit_in)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: network did not drain within %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
    end
  endtask

  // YX rule, y resolved before x
  function automatic int expected_port(input logic [3:0] dx, input logic [3:0] dy);
    if (dy > NODE_Y) return noc_pkg::NORTH;
    if (dy < NODE_Y) return noc_pkg::SOUTH;
    if (dx > NODE_X) return noc_pkg::EAST;
    if (dx < NODE_X) return noc_pkg::WEST;
    return noc_pkg::LOCAL;
  endfunction

  task automatic send_packet(input int src, input logic [3:0] dx, input logic [3:0] dy,
                             input int len);
    noc_pkg::head_t h;
    noc_pkg::flit_t f;
    int             o;
    h.len         = 8'(len);
    h.dest.dest_x = dx;
    h.dest.dest_y = dy;
    o = expected_port(dx, dy);
    f = noc_pkg::flit_t'(h);
    for (int k = 0; k < len; k++) begin
      inject_q[src].push_back(f);
      exp_q[o*NP+src].push_back(f);
      f = {4'(src), 12'(serial)}; // body flits tagged with their source
      serial++;
    end
    inj_cnt[src] += len;
  endtask

  // ####################################################################
  // neighbor models and output monitor, all on the falling edge
  // ####################################################################
  task automatic sample_outputs();
    noc_pkg::flit_t f;
    noc_pkg::head_t h;
    int             found;
    for (int p = 0; p < NP; p++) begin
      if (out_link[p].valid) begin
        f = out_link[p].flit;
        h = noc_pkg::head_t'(f);
        rx_cnt[p]++;
        pending[p]++;
        if (cur_src[p] < 0) begin
          found = -1;
          for (int i = 0; i < NP; i++) begin
            if (found < 0 && exp_q[p*NP+i].size() > 0 && exp_q[p*NP+i][0] == f) found = i;
          end
          check_eq(found >= 0, 1, $sformatf("head %h on output %0d matches no packet", f, p));
          if (found >= 0) begin
            void'(exp_q[p*NP+found].pop_front());
            if (h.len > 8'd1) begin
              cur_src[p] = found;
              left[p]    = h.len - 1;
            end
          end
        end else begin
          check_eq(f, exp_q[p*NP+cur_src[p]].pop_front(),
                   $sformatf("body flit on output %0d", p));
          left[p]--;
          if (left[p] == 0) cur_src[p] = -1;
        end
      end
    end
  endtask

  task automatic return_credits();
    for (int p = 0; p < NP; p++) begin
      credit_in[p] = 1'b0;
      if (pending[p] > 0 && !hold[p] && (!rand_delay || $urandom_range(3, 0) != 0)) begin
        credit_in[p] = 1'b1;
        pending[p]--;
      end
    end
  endtask

  task automatic drive_inputs();
    for (int p = 0; p < NP; p++) begin
      in_link[p] = '0;
      if (inject_q[p].size() > 0 && up_credit[p] > 0) begin
        in_link[p].valid = 1'b1;
        in_link[p].flit  = inject_q[p].pop_front();
        up_credit[p]--;
      end
      if (credit_out[p]) begin // usable from the next cycle on
        up_credit[p]++;
        crd_cnt[p]++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      sample_outputs();
      return_credits();
      drive_inputs();
    end
  end

  // ####################################################################
  // test sequence
  // ####################################################################
  task automatic wait_drain();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int p = 0; p < NP; p++) begin
        if (inject_q[p].size() > 0 || pending[p] > 0) busy = 1'b1;
      end
      for (int k = 0; k < NP*NP; k++) begin
        if (exp_q[k].size() > 0) busy = 1'b1;
      end
    end
  endtask

  task automatic close_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int e;
    int base;
    void'($urandom(32'h5259));
    rst_n      = 1'b0;
    in_link    = '0;
    credit_in  = '0;
    hold       = '0;
    rand_delay = 1'b0;
    for (int p = 0; p < NP; p++) begin
      up_credit[p] = FIFO_DEPTH;
      cur_src[p]   = -1;
    end
    repeat (5) @(negedge clk);
    rst_n <= 1'b1;

    e = errors;
    repeat (10) @(posedge clk);
    for (int p = 0; p < NP; p++) begin
      check_eq(rx_cnt[p], 0, $sformatf("output %0d valid while idle", p));
      check_eq(crd_cnt[p], 0, $sformatf("credit_out %0d pulsed while idle", p));
    end
    close_test("test 1 idle after reset", e);

    e = errors;
    send_packet(noc_pkg::LOCAL, 4'd2, 4'd3, 1);
    send_packet(noc_pkg::LOCAL, 4'd2, 4'd1, 1);
    send_packet(noc_pkg::LOCAL, 4'd3, 4'd2, 1);
    send_packet(noc_pkg::LOCAL, 4'd1, 4'd2, 1);
    send_packet(noc_pkg::LOCAL, 4'd2, 4'd2, 1);
    wait_drain();
    for (int p = 0; p < NP; p++) check_eq(rx_cnt[p], 1, $sformatf("flits on output %0d", p));
    close_test("test 2 single flit routing", e);

    e = errors;
    rand_delay = 1'b1;
    send_packet(noc_pkg::LOCAL, 4'd3, 4'd2, 4);
    send_packet(noc_pkg::LOCAL, 4'd2, 4'd4, 3);
    send_packet(noc_pkg::WEST,  4'd4, 4'd2, 5);
    send_packet(noc_pkg::NORTH, 4'd2, 4'd2, 3);
    send_packet(noc_pkg::NORTH, 4'd2, 4'd0, 2);
    send_packet(noc_pkg::EAST,  4'd0, 4'd2, 4);
    wait_drain();
    close_test("test 3 multi flit packets", e);

    e = errors;
    send_packet(noc_pkg::SOUTH, 4'd2, 4'd3, 3);
    send_packet(noc_pkg::LOCAL, 4'd0, 4'd3, 3);
    send_packet(noc_pkg::SOUTH, 4'd1, 4'd4, 3);
    send_packet(noc_pkg::LOCAL, 4'd4, 4'd6, 3);
    send_packet(noc_pkg::SOUTH, 4'd3, 4'd5, 3);
    send_packet(noc_pkg::LOCAL, 4'd2, 4'd5, 3);
    wait_drain();
    close_test("test 4 contention on north", e);

    e = errors;
    rand_delay = 1'b0;
    hold[noc_pkg::EAST] = 1'b1;
    base = rx_cnt[noc_pkg::EAST];
    send_packet(noc_pkg::LOCAL, 4'd5, 4'd2, 8);
    repeat (30) @(posedge clk);
    check_eq(rx_cnt[noc_pkg::EAST] - base, FIFO_DEPTH, "flits sent without credit return");
    hold[noc_pkg::EAST] = 1'b0;
    wait_drain();
    check_eq(rx_cnt[noc_pkg::EAST] - base, 8, "flits sent after credit release");
    close_test("test 5 credit back-pressure", e);

    e = errors;
    for (int p = 0; p < NP; p++) begin
      check_eq(crd_cnt[p], inj_cnt[p], $sformatf("credit_out pulses on input %0d", p));
    end
    close_test("test 6 credit return count", e);

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- logic/credit_link.sv
module credit_link #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic send,
  input  logic credit_in,
  output logic credit_ok,
  input  logic pop,
  output logic credit_out
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 2);

  logic [CNT_W-1:0] credits; // free slots in the downstream FIFO
  logic             spend;

  // ####################################################################
  // output side, one credit per flit sent
  // ####################################################################
  assign credit_ok = (credits != '0);
  assign spend     = send & credit_ok;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= CNT_W'(FIFO_DEPTH);
    end else begin
      case ({spend, credit_in})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // ####################################################################
  // input side, slot freed by a pop goes straight back upstream
  // ####################################################################
  assign credit_out = pop;

  // neighbor returned more credits than it has buffer slots
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CNT_W'(FIFO_DEPTH))
    else $error("credit_link: credit count above FIFO depth");

endmodule

//--- logic/crossbar.sv
module crossbar (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::NUM_PORTS-1:0] grant,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       send,
  input  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]             head_flit,
  output noc_pkg::link_t [noc_pkg::NUM_PORTS-1:0]             out_link
);

  logic [noc_pkg::NUM_PORTS-1:0]           valid_q;
  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] flit_q;
  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] mux_flit;

  // inputs physically wired to each output
  function automatic logic [noc_pkg::NUM_PORTS-1:0] wired_inputs(input int o);
    case (o)
      noc_pkg::NORTH: return (5'b1 << noc_pkg::SOUTH) | (5'b1 << noc_pkg::LOCAL);
      noc_pkg::SOUTH: return (5'b1 << noc_pkg::NORTH) | (5'b1 << noc_pkg::LOCAL);
      noc_pkg::EAST:  return ~(5'b1 << noc_pkg::EAST);
      noc_pkg::WEST:  return ~(5'b1 << noc_pkg::WEST);
      default:        return '1; // local output sees every input
    endcase
  endfunction

  always_comb begin
    logic [noc_pkg::NUM_PORTS-1:0] wired;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      wired       = wired_inputs(o);
      mux_flit[o] = '0;
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        if (grant[o][i] && wired[i]) mux_flit[o] = mux_flit[o] | head_flit[i];
      end
      out_link[o] = '{valid: valid_q[o], flit: flit_q[o]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) valid_q <= '0;
    else        valid_q <= send;
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      if (send[o]) flit_q[o] <= mux_flit[o];
    end
  end

endmodule

//--- logic/flit_fifo.sv
module flit_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push,
  input  noc_pkg::flit_t push_flit,
  input  logic           pop,
  output logic           head_valid,
  output noc_pkg::flit_t head_flit,
  output logic           next_valid,
  output noc_pkg::flit_t next_flit
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  noc_pkg::flit_t   mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_next;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign rd_next    = wrap_inc(rd_ptr);
  assign do_pop     = pop & head_valid;
  assign head_valid = (count != '0);
  assign head_flit  = mem[rd_ptr];
  assign next_valid = (count > CNT_W'(1)); // entry behind the head
  assign next_flit  = mem[rd_next];

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_flit;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wrap_inc(wr_ptr);
      if (do_pop) rd_ptr <= rd_next;
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // upstream credit counter must keep a full buffer from being written
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count < CNT_W'(FIFO_DEPTH)))
    else $error("flit_fifo: push while full");

endmodule

//--- logic/noc_pkg.sv
package noc_pkg;

  localparam int FLIT_W    = 16;
  localparam int NUM_PORTS = 5;

  typedef logic [FLIT_W-1:0] flit_t;

  typedef struct packed {
    logic [3:0] dest_x;
    logic [3:0] dest_y;
  } dest_t;

  // head flit view, len counts the head itself
  typedef struct packed {
    logic [7:0] len;
    dest_t      dest;
  } head_t;

  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  typedef enum logic [2:0] {
    NORTH = 3'd0,
    SOUTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    LOCAL = 3'd4
  } port_e;

  typedef enum logic {
    HEAD = 1'b0,
    BODY = 1'b1
  } trk_state_e;

endpackage

//--- logic/output_arbiter.sv
module output_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [noc_pkg::NUM_PORTS-1:0] req,
  input  logic [noc_pkg::NUM_PORTS-1:0] last,
  input  logic                          fire,
  output logic [noc_pkg::NUM_PORTS-1:0] grant
);

  noc_pkg::port_e                ptr;  // last winner
  noc_pkg::port_e                pick_idx;
  logic [noc_pkg::NUM_PORTS-1:0] pick;
  logic [noc_pkg::NUM_PORTS-1:0] grant_q;
  logic                          locked;
  logic                          done;

  // ####################################################################
  // round-robin search starting after the previous winner
  // ####################################################################
  always_comb begin
    int idx;
    pick     = '0;
    pick_idx = ptr;
    for (int k = 1; k <= noc_pkg::NUM_PORTS; k++) begin
      idx = (int'(ptr) + k) % noc_pkg::NUM_PORTS;
      if (pick == '0 && req[idx]) begin
        pick[idx] = 1'b1;
        pick_idx  = noc_pkg::port_e'(idx);
      end
    end
  end

  assign grant = locked ? grant_q : pick;
  assign done  = fire & |(grant & last); // tail flit leaves this cycle

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      locked  <= 1'b0;
      grant_q <= '0;
      ptr     <= noc_pkg::LOCAL; // north gets first turn
    end else if (!locked) begin
      if (|pick) begin
        ptr     <= pick_idx;
        grant_q <= pick;
        locked  <= !done;
      end
    end else if (done) begin
      locked  <= 1'b0;
      grant_q <= '0;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant))
    else $error("output_arbiter: more than one grant");

endmodule

//--- logic/packet_tracker.sv
module packet_tracker (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           head_valid,
  input  noc_pkg::flit_t head_flit,
  input  logic           pop,
  output noc_pkg::dest_t dest,
  output logic           is_head,
  output logic           last_flit
);

  noc_pkg::trk_state_e state;
  noc_pkg::head_t      head_view;
  noc_pkg::dest_t      dest_q;
  logic [7:0]          remain;
  logic                take;

  assign head_view = noc_pkg::head_t'(head_flit);
  assign take      = pop & head_valid;
  assign is_head   = (state == noc_pkg::HEAD);

  // body flits reuse the address latched from the head
  assign dest = is_head ? head_view.dest : dest_q;

  // len 0 is treated like a single flit packet
  assign last_flit = is_head ? (head_view.len <= 8'd1) : (remain == 8'd1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= noc_pkg::HEAD;
      remain <= '0;
    end else if (take) begin
      if (is_head) begin
        if (head_view.len > 8'd1) begin
          state  <= noc_pkg::BODY;
          remain <= head_view.len - 8'd1; // body flits still to come
        end
      end else begin
        remain <= remain - 8'd1;
        if (remain == 8'd1) state <= noc_pkg::HEAD;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && is_head) dest_q <= head_view.dest;
  end

endmodule

//--- logic/router_ctrl.sv
module router_ctrl #(
  parameter logic [3:0] NODE_X = 4'd0,
  parameter logic [3:0] NODE_Y = 4'd0
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       head_valid,
  input  noc_pkg::dest_t [noc_pkg::NUM_PORTS-1:0]             dest,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       is_head,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       last_flit,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       credit_ok,
  output logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::NUM_PORTS-1:0] grant,
  output logic [noc_pkg::NUM_PORTS-1:0]                       pop,
  output logic [noc_pkg::NUM_PORTS-1:0]                       send
);

  noc_pkg::port_e                                         route [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::NUM_PORTS-1:0] req;  // [output][input]

  // y first, then x
  function automatic noc_pkg::port_e route_yx(input noc_pkg::dest_t d);
    if (d.dest_y > NODE_Y) return noc_pkg::NORTH;
    if (d.dest_y < NODE_Y) return noc_pkg::SOUTH;
    if (d.dest_x > NODE_X) return noc_pkg::EAST;
    if (d.dest_x < NODE_X) return noc_pkg::WEST;
    return noc_pkg::LOCAL;
  endfunction

  function automatic logic turn_ok(input noc_pkg::port_e from, input noc_pkg::port_e to);
    logic x_in;
    logic y_out;
    x_in  = (from == noc_pkg::EAST) || (from == noc_pkg::WEST);
    y_out = (to == noc_pkg::NORTH) || (to == noc_pkg::SOUTH);
    // local loopback is the only legal same-port turn
    return !(x_in && y_out) && ((from != to) || (from == noc_pkg::LOCAL));
  endfunction

  // ####################################################################
  // requests, only packet heads compete for a free output
  // ####################################################################
  always_comb begin
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      route[i] = route_yx(dest[i]);
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        req[o][i] = head_valid[i] & is_head[i] & (route[i] == noc_pkg::port_e'(o));
      end
    end
  end

  for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : g_arb
    output_arbiter u_arb (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req[o]),
      .last  (last_flit),
      .fire  (send[o]),
      .grant (grant[o])
    );
  end

  // granted flit moves only when the downstream buffer has room
  always_comb begin
    pop = '0;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      send[o] = (|(grant[o] & head_valid)) & credit_ok[o];
      pop     = pop | (grant[o] & {noc_pkg::NUM_PORTS{send[o]}});
    end
  end

  for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : g_chk
    a_legal_turn: assert property (@(posedge clk) disable iff (!rst_n)
      (head_valid[i] && is_head[i]) |-> turn_ok(noc_pkg::port_e'(i), route[i]))
      else $error("router_ctrl: illegal turn on input %0d", i);
  end

endmodule

//--- logic/router_node.sv
module router_node #(
  parameter logic [3:0] NODE_X     = 4'd0,
  parameter logic [3:0] NODE_Y     = 4'd0,
  parameter int         FIFO_DEPTH = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  noc_pkg::link_t [noc_pkg::NUM_PORTS-1:0] in_link,
  output logic [noc_pkg::NUM_PORTS-1:0]           credit_out,
  output noc_pkg::link_t [noc_pkg::NUM_PORTS-1:0] out_link,
  input  logic [noc_pkg::NUM_PORTS-1:0]           credit_in
);

  logic [noc_pkg::NUM_PORTS-1:0]                       head_valid;
  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]             head_flit;
  noc_pkg::dest_t [noc_pkg::NUM_PORTS-1:0]             dest;
  logic [noc_pkg::NUM_PORTS-1:0]                       is_head;
  logic [noc_pkg::NUM_PORTS-1:0]                       last_flit;
  logic [noc_pkg::NUM_PORTS-1:0]                       credit_ok;
  logic [noc_pkg::NUM_PORTS-1:0]                       pop;
  logic [noc_pkg::NUM_PORTS-1:0]                       send;
  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::NUM_PORTS-1:0] grant;

  // ####################################################################
  // per-port input buffering, packet tracking and link credits
  // ####################################################################
  for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_port
    flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (in_link[p].valid),
      .push_flit  (in_link[p].flit),
      .pop        (pop[p]),
      .head_valid (head_valid[p]),
      .head_flit  (head_flit[p]),
      .next_valid (),
      .next_flit  ()
    );

    packet_tracker u_trk (
      .clk        (clk),
      .rst_n      (rst_n),
      .head_valid (head_valid[p]),
      .head_flit  (head_flit[p]),
      .pop        (pop[p]),
      .dest       (dest[p]),
      .is_head    (is_head[p]),
      .last_flit  (last_flit[p])
    );

    credit_link #(.FIFO_DEPTH(FIFO_DEPTH)) u_crd (
      .clk        (clk),
      .rst_n      (rst_n),
      .send       (send[p]),
      .credit_in  (credit_in[p]),
      .credit_ok  (credit_ok[p]),
      .pop        (pop[p]),
      .credit_out (credit_out[p])
    );
  end

  router_ctrl #(
    .NODE_X (NODE_X),
    .NODE_Y (NODE_Y)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .dest       (dest),
    .is_head    (is_head),
    .last_flit  (last_flit),
    .credit_ok  (credit_ok),
    .grant      (grant),
    .pop        (pop),
    .send       (send)
  );

  crossbar u_xbar (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .send      (send),
    .head_flit (head_flit),
    .out_link  (out_link)
  );

endmodule

//--- tb.f
logic/noc_pkg.sv
logic/flit_fifo.sv
logic/packet_tracker.sv
logic/output_arbiter.sv
logic/router_ctrl.sv
logic/crossbar.sv
logic/credit_link.sv
logic/router_node.sv
dv/router_tb.sv
